//--- Makefile
# Verilator build and run for the MPU testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f mpu_top.f --top-module mpu_tb

run: compile
	./obj_dir/Vmpu_tb | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- mpu_top.f
source/mpu_pkg.sv
source/mpu_cfg_if.sv
source/mpu_region_if.sv
source/mpu_fault_if.sv
source/mpu_cfg_regs.sv
source/mpu_region_table.sv
source/mpu_access_check.sv
source/mpu_top.sv
sim/mpu_checker.sv
sim/mpu_tb.sv

//--- sim/mpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mpu_checker (
    input wire logic                       clock,
    input wire logic                       rst_n,
    input wire logic                       mem_request,
    input wire logic                       supervisor_mode,
    input wire logic                       load_fault,
    input wire logic                       store_fault,
    input wire logic [mpu_pkg::count_w-1:0] region_count
);
    import mpu_pkg::*;

    // Bypassed cycle, outputs stay quiet one cycle later
    assert property (@(posedge clock) disable iff (!rst_n)
        (!mem_request || supervisor_mode) |=> (!load_fault && !store_fault))
        else $error("Fault raised after a supervisor or idle cycle");

    // One access per cycle, so only one direction can fault
    assert property (@(posedge clock) disable iff (!rst_n)
        !(load_fault && store_fault))
        else $error("Load and store fault high together");

    assert property (@(posedge clock) disable iff (!rst_n)
        region_count <= count_w'(num_regions))
        else $error("Region count above eight");

endmodule

bind mpu_top mpu_checker u_checker (
    .clock           (clock),
    .rst_n           (rst_n),
    .mem_request     (mem_request),
    .supervisor_mode (supervisor_mode),
    .load_fault      (load_fault),
    .store_fault     (store_fault),
    .region_count    (cfg_bus.region_count)
);

`default_nettype wire

//--- sim/mpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mpu_tb;
    import mpu_pkg::*;

    logic        clock;
    logic        rst_n;
    logic        mem_request;
    logic        mem_write;
    logic [31:0] mem_addr;
    logic        supervisor_mode;
    logic        cfg_write;
    logic        cfg_read;
    logic [1:0]  cfg_addr;
    logic [31:0] cfg_wdata;
    logic [31:0] cfg_rdata;
    logic        load_fault;
    logic        store_fault;

    // Reference model of the region list and the sticky state
    logic [desc_base_w-1:0] model_base [num_regions];
    logic [desc_size_w-1:0] model_size [num_regions];
    logic                   model_rd   [num_regions];
    logic                   model_wr   [num_regions];
    int                     model_count;
    int                     model_next;         // Slot the next add lands in
    logic                   model_load_flag;
    logic                   model_store_flag;
    logic [31:0]            model_fault_addr;

    logic [1:0]  exp_now;    // Expected faults for the access on the pins now
    string       name_now;

    mpu_top uut (
        .clock           (clock),
        .rst_n           (rst_n),
        .mem_request     (mem_request),
        .mem_write       (mem_write),
        .mem_addr        (mem_addr),
        .supervisor_mode (supervisor_mode),
        .cfg_write       (cfg_write),
        .cfg_read        (cfg_read),
        .cfg_addr        (cfg_addr),
        .cfg_wdata       (cfg_wdata),
        .cfg_rdata       (cfg_rdata),
        .load_fault      (load_fault),
        .store_fault     (store_fault)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;  // 4 ns period
    end

    function automatic void model_clear();
        for (int i = 0; i < num_regions; i++) begin
            model_base[i] = '0;
            model_size[i] = '0;
            model_rd[i]   = 1'b0;
            model_wr[i]   = 1'b0;
        end
        model_count = 0;
        model_next  = 0;
    endfunction

    // Empty descriptors are dropped and a full list loses its oldest entry
    function automatic void model_add(input logic [31:0] desc);
        if (!desc[desc_read_bit] && !desc[desc_write_bit])
            return;
        model_base[model_next] = desc[31:12];
        model_size[model_next] = desc[3:0];
        model_rd[model_next]   = desc[desc_read_bit];
        model_wr[model_next]   = desc[desc_write_bit];
        model_next = (model_next + 1) % num_regions;
        if (model_count < num_regions)
            model_count++;
    endfunction

    // Returns {load fault, store fault} for one access
    function automatic logic [1:0] expected_faults(input logic req, input logic wr,
                                                   input logic sup, input logic [31:0] addr);
        logic [19:0] page;
        logic        load_ok;
        logic        store_ok;
        page     = addr[31:12];
        load_ok  = 1'b0;
        store_ok = 1'b0;
        if (!req || sup)
            return 2'b00;
        for (int i = 0; i < num_regions; i++) begin
            // Naturally aligned block where pages agree above the size code
            if ((page >> model_size[i]) == (model_base[i] >> model_size[i])) begin
                load_ok  = load_ok | model_rd[i];
                store_ok = store_ok | model_wr[i];
            end
        end
        return {!wr && !load_ok, wr && !store_ok};
    endfunction

    function automatic logic [31:0] expected_status();
        logic [31:0] word;
        word                         = 32'h0;
        word[3:0]                    = 4'(model_count);
        word[status_fault_load_bit]  = model_load_flag;
        word[status_fault_store_bit] = model_store_flag;
        return word;
    endfunction

    function automatic logic [31:0] make_desc(input logic [19:0] base, input logic rd,
                                              input logic wr, input logic [3:0] size);
        return {base, 6'b0, wr, rd, size};
    endfunction

    // Random address that lands inside a model slot
    function automatic logic [31:0] addr_in_region(input int slot);
        logic [19:0] span;
        logic [19:0] page;
        span = (20'h1 << model_size[slot]) - 20'h1;
        page = (model_base[slot] & ~span) | (20'($urandom()) & span);
        return {page, 12'($urandom())};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "Stopped at first error");
        end
    endtask

    // One cycle on the data port with register strobes low
    task automatic drive_access(input string name, input logic req, input logic wr,
                                input logic [31:0] addr, input logic sup);
        logic [1:0] faults;
        @(posedge clock);
        #1;
        faults          = expected_faults(req, wr, sup, addr);
        mem_request     = req;
        mem_write       = wr;
        mem_addr        = addr;
        supervisor_mode = sup;
        cfg_write       = 1'b0;
        cfg_read        = 1'b0;
        exp_now         = faults;
        name_now        = name;
        if (faults != 2'b00) begin
            if (!model_load_flag && !model_store_flag)
                model_fault_addr = addr;     // First fault since flags were clear
            model_load_flag  = model_load_flag | faults[1];
            model_store_flag = model_store_flag | faults[0];
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++)
            drive_access("idle", 1'b0, 1'b0, 32'h0, 1'b0);
    endtask

    // Idle cycle first so a pending fault reaches the flags before the write
    task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
        idle_cycles(1);
        @(posedge clock);
        #1;
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        if (addr == reg_control && data[ctrl_clear_bit]) begin
            model_clear();
        end else if (addr == reg_region) begin
            model_add(data);
        end else if (addr == reg_status) begin
            model_load_flag  = 1'b0;
            model_store_flag = 1'b0;
        end
        @(posedge clock);
        #1;
        cfg_write = 1'b0;
    endtask

    task automatic read_reg(input string name, input logic [1:0] addr,
                            input logic [31:0] expected);
        idle_cycles(1);
        @(posedge clock);
        #1;
        cfg_read = 1'b1;
        cfg_addr = addr;
        @(posedge clock);
        #1;
        cfg_read = 1'b0;
        check_value(name, expected, cfg_rdata);  // Latched at the read edge
    endtask

    // Supervisor and idle cycles against whatever regions are loaded
    task automatic bypass_sweep(input string name, input int n);
        logic [31:0] addr;
        for (int i = 0; i < n; i++) begin
            addr = $urandom();
            drive_access(name, 1'b1, addr[0], addr, 1'b1);
            drive_access(name, 1'b0, addr[1], addr, 1'b0);
        end
    endtask

    // Compare process one cycle after the DUT samples each access
    initial begin : compare_outputs
        logic [1:0] exp_pipe;
        string      name_pipe;
        forever begin
            @(posedge clock);
            exp_pipe  = exp_now;   // Stimulus moves 1 ns later
            name_pipe = name_now;
            @(negedge clock);
            check_value(name_pipe, {30'h0, exp_pipe}, {30'h0, load_fault, store_fault});
        end
    end

    initial begin : stimulus
        logic [31:0] addr;
        logic [31:0] addr_a;
        logic [1:0]  perm;
        int          slot;
        void'($urandom(32'hbc06_0b53));
        rst_n            = 1'b0;
        mem_request      = 1'b0;
        mem_write        = 1'b0;
        mem_addr         = 32'h0;
        supervisor_mode  = 1'b0;
        cfg_write        = 1'b0;
        cfg_read         = 1'b0;
        cfg_addr         = 2'd0;
        cfg_wdata        = 32'h0;
        exp_now          = 2'b00;
        name_now         = "reset";
        model_load_flag  = 1'b0;
        model_store_flag = 1'b0;
        model_fault_addr = 32'h0;
        model_clear();
        repeat (5) @(posedge clock);
        #1;
        rst_n = 1'b1;

        // Every user access is denied by the empty table after reset
        read_reg("reset_status", reg_status, expected_status());
        for (int i = 0; i < 8; i++)
            drive_access("reset_fault", 1'b1, i[0], $urandom(), 1'b0);
        read_reg("reset_fault_addr", reg_fault_addr, model_fault_addr);

        // Random regions and then a read-only one in slot 5
        for (int r = 0; r < 5; r++) begin
            perm = 2'($urandom_range(1, 3));
            write_reg(reg_region, make_desc(20'($urandom()), perm[0], perm[1],
                                            4'($urandom_range(0, 15))));
        end
        write_reg(reg_region, make_desc(20'($urandom()), 1'b1, 1'b0,
                                        4'($urandom_range(0, 4))));
        for (int i = 0; i < 60; i++) begin
            slot = int'($urandom_range(0, 5));
            if ($urandom_range(0, 2) == 0)
                addr = $urandom();
            else
                addr = addr_in_region(slot);
            drive_access("region_access", 1'b1, addr[2], addr, 1'b0);
        end
        for (int i = 0; i < 8; i++)
            drive_access("read_only_access", 1'b1, i[0], addr_in_region(5), 1'b0);
        read_reg("region_status", reg_status, expected_status());

        bypass_sweep("bypass_loaded", 24);

        // Overfilling drops the two oldest regions
        write_reg(reg_control, 32'h1);
        for (int r = 0; r < 10; r++)
            write_reg(reg_region, make_desc(20'(r * 32), 1'b1, 1'b1, 4'd2));
        read_reg("full_status", reg_status, expected_status());
        for (int r = 0; r < 10; r++) begin
            drive_access("oldest_load", 1'b1, 1'b0, {20'(r * 32), 12'h0}, 1'b0);
            drive_access("oldest_store", 1'b1, 1'b1, {20'(r * 32 + 3), 12'hffc}, 1'b0);
        end
        write_reg(reg_region, make_desc(20'h12345, 1'b0, 1'b0, 4'd3));
        read_reg("empty_desc_full", reg_status, expected_status());
        drive_access("empty_desc_keep", 1'b1, 1'b1, {20'(2 * 32), 12'h10}, 1'b0);

        // Clear empties the table
        write_reg(reg_control, 32'h1);
        read_reg("clear_status", reg_status, expected_status());
        write_reg(reg_region, make_desc(20'h00abc, 1'b0, 1'b0, 4'd0));
        read_reg("empty_desc_clear", reg_status, expected_status());
        for (int i = 0; i < 16; i++)
            drive_access("after_clear", 1'b1, i[0], $urandom(), 1'b0);
        bypass_sweep("bypass_empty", 8);

        // Sticky flags and first fault address
        write_reg(reg_status, 32'h0);
        read_reg("flags_cleared", reg_status, expected_status());
        addr_a = $urandom();
        drive_access("first_store_fault", 1'b1, 1'b1, addr_a, 1'b0);
        drive_access("second_load_fault", 1'b1, 1'b0, $urandom(), 1'b0);
        read_reg("sticky_status", reg_status, expected_status());
        read_reg("first_fault_addr", reg_fault_addr, model_fault_addr);
        write_reg(reg_status, 32'h0);
        read_reg("flags_cleared_again", reg_status, expected_status());
        drive_access("new_load_fault", 1'b1, 1'b0, ~addr_a, 1'b0);
        read_reg("new_fault_addr", reg_fault_addr, model_fault_addr);
        read_reg("new_fault_status", reg_status, expected_status());

        idle_cycles(3);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/mpu_access_check.sv
`timescale 1ns/1ps
`default_nettype none

module mpu_access_check (
    input  logic         clock,
    input  logic         rst_n,
    input  logic         mem_request,
    input  logic         mem_write,      // 0 load, 1 store
    input  logic [31:0]  mem_addr,
    input  logic         supervisor_mode,
    mpu_region_if.check  regions,
    output logic         load_fault,
    output logic         store_fault,
    mpu_fault_if.check   fault
);
    import mpu_pkg::*;

    logic [desc_base_w-1:0] page;         // Address above the page offset
    logic                   load_deny;
    logic                   store_deny;
    logic [31:0]            fault_addr_q;

    assign page = mem_addr[31:page_bits];

    always_comb begin
        // Deny by default, any permitting slot lifts it
        load_deny  = mem_request && !mem_write && !supervisor_mode;
        store_deny = mem_request &&  mem_write && !supervisor_mode;
        for (int i = 0; i < num_regions; i++) begin
            if (((page ^ regions.base[i]) & regions.mask[i]) == '0) begin
                if (regions.read_en[i])
                    load_deny = 1'b0;
                if (regions.write_en[i])
                    store_deny = 1'b0;
            end
        end
    end

    // One stage, result valid for exactly one cycle
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            load_fault  <= 1'b0;
            store_fault <= 1'b0;
        end else begin
            load_fault  <= load_deny;
            store_fault <= store_deny;
        end
    end

    // Address rides along with the fault bits
    always_ff @(posedge clock) begin
        fault_addr_q <= mem_addr;
    end

    assign fault.fault_valid = load_fault || store_fault;
    assign fault.load        = load_fault;
    assign fault.store       = store_fault;
    assign fault.addr        = fault_addr_q;

endmodule

`default_nettype wire

//--- source/mpu_cfg_if.sv
`timescale 1ns/1ps
`default_nettype none

// Region updates from the register block into the table
interface mpu_cfg_if;
    import mpu_pkg::*;

    logic               clear;        // One-cycle pulse that empties every slot
    logic               add;          // One-cycle pulse that stores the descriptor
    logic [31:0]        descriptor;   // Raw region word as written
    logic [count_w-1:0] region_count; // Valid slot count for the status register

    modport regs (
        output clear,
        output add,
        output descriptor,
        input  region_count
    );

    modport tbl (
        input  clear,
        input  add,
        input  descriptor,
        output region_count
    );

endinterface

`default_nettype wire

//--- source/mpu_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mpu_cfg_regs (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        cfg_write,
    input  logic        cfg_read,
    input  logic [1:0]  cfg_addr,
    input  logic [31:0] cfg_wdata,
    output logic [31:0] cfg_rdata,
    mpu_cfg_if.regs     cfg,
    mpu_fault_if.regs   fault
);
    import mpu_pkg::*;

    logic        status_wr;      // Software clears the sticky flags
    logic        fault_load_q;   // Sticky, a load was denied
    logic        fault_store_q;  // Sticky, a store was denied
    logic [31:0] fault_addr_q;   // First denied address since flags were clear
    logic        first_fault;
    logic [31:0] status_word;
    logic [31:0] read_word;

    // Write decode, all strobes act at the edge of the write
    assign status_wr = cfg_write && (cfg_addr == reg_status);

    assign cfg.clear = cfg_write && (cfg_addr == reg_control)
                       && cfg_wdata[ctrl_clear_bit];

    // Descriptors with neither permission are dropped here
    assign cfg.add = cfg_write && (cfg_addr == reg_region)
                     && (cfg_wdata[desc_read_bit] || cfg_wdata[desc_write_bit]);

    assign cfg.descriptor = cfg_wdata;  // Table picks the fields apart

    // Address is taken only when no flag is pending,
    // or when the same write wipes the flags
    assign first_fault = fault.fault_valid
                         && (status_wr || !(fault_load_q || fault_store_q));

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            fault_load_q  <= 1'b0;
            fault_store_q <= 1'b0;
        end else begin
            if (status_wr) begin
                fault_load_q  <= 1'b0;
                fault_store_q <= 1'b0;
            end
            // A fault on the clearing edge is kept, it lands after the clear
            if (fault.fault_valid) begin
                if (fault.load)
                    fault_load_q <= 1'b1;
                if (fault.store)
                    fault_store_q <= 1'b1;
            end
        end
    end

    // Fault address, visible to software so it starts at zero
    always_ff @(posedge clock) begin
        if (!rst_n)
            fault_addr_q <= '0;
        else if (first_fault)
            fault_addr_q <= fault.addr;
    end

    // Status layout: count low, sticky flags at 8 and 9
    always_comb begin
        status_word                         = '0;
        status_word[count_w-1:0]            = cfg.region_count;
        status_word[status_fault_load_bit]  = fault_load_q;
        status_word[status_fault_store_bit] = fault_store_q;
    end

    always_comb begin
        case (cfg_addr)
            reg_status:     read_word = status_word;
            reg_fault_addr: read_word = fault_addr_q;
            default:        read_word = '0;  // Control and region are write-only
        endcase
    end

    // Read data held until the next read
    always_ff @(posedge clock) begin
        if (!rst_n)
            cfg_rdata <= '0;
        else if (cfg_read)
            cfg_rdata <= read_word;
    end

endmodule

`default_nettype wire

//--- source/mpu_fault_if.sv
`timescale 1ns/1ps
`default_nettype none

// Fault reports from the checker into the register block
interface mpu_fault_if;

    logic        fault_valid;  // Either fault this cycle
    logic        load;         // Denied load
    logic        store;        // Denied store
    logic [31:0] addr;         // Address of the denied access

    modport check (
        output fault_valid,
        output load,
        output store,
        output addr
    );

    modport regs (
        input fault_valid,
        input load,
        input store,
        input addr
    );

endinterface

`default_nettype wire

//--- source/mpu_pkg.sv
`default_nettype none

package mpu_pkg;

    // Region store geometry
    localparam int num_regions  = 8;
    localparam int region_idx_w = 3;  // Slot index, wraps over all eight slots
    localparam int count_w      = 4;  // Holds 0 to 8

    // Descriptor layout
    // Bits 31:12 base page, 5 write, 4 read, 3:0 size code
    localparam int desc_base_lsb  = 12;
    localparam int desc_base_w    = 20;
    localparam int desc_write_bit = 5;
    localparam int desc_read_bit  = 4;
    localparam int desc_size_lsb  = 0;
    localparam int desc_size_w    = 4;   // Size = 4 KiB << code

    // Page offset bits, never compared
    localparam int page_bits = 12;

    // Register map on the two-bit config address
    localparam logic [1:0] reg_control    = 2'd0;
    localparam logic [1:0] reg_region     = 2'd1;
    localparam logic [1:0] reg_status     = 2'd2;
    localparam logic [1:0] reg_fault_addr = 2'd3;

    // Status word, count sits in bits 3:0
    localparam int status_fault_load_bit  = 8;
    localparam int status_fault_store_bit = 9;

    // Control word
    localparam int ctrl_clear_bit = 0;  // Writing one empties the table

endpackage

`default_nettype wire

//--- source/mpu_region_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded slot contents from the table into the checker
interface mpu_region_if;
    import mpu_pkg::*;

    logic [num_regions-1:0][desc_base_w-1:0] base;  // Page number per slot
    logic [num_regions-1:0][desc_base_w-1:0] mask;  // Ones on compared page bits
    logic [num_regions-1:0]                  write_en;
    logic [num_regions-1:0]                  read_en;

    modport tbl (
        output base,
        output mask,
        output write_en,
        output read_en
    );

    modport check (
        input base,
        input mask,
        input write_en,
        input read_en
    );

endinterface

`default_nettype wire

//--- source/mpu_region_table.sv
`timescale 1ns/1ps
`default_nettype none

module mpu_region_table (
    input  logic       clock,
    input  logic       rst_n,
    mpu_cfg_if.tbl     cfg,
    mpu_region_if.tbl  regions
);
    import mpu_pkg::*;

    logic [num_regions-1:0][desc_base_w-1:0] base_q;
    logic [num_regions-1:0][desc_base_w-1:0] mask_q;
    logic [num_regions-1:0]                  write_en_q;
    logic [num_regions-1:0]                  read_en_q;
    logic [region_idx_w-1:0]                 next_slot;  // Oldest slot once full
    logic [count_w-1:0]                      count_q;
    logic [desc_size_w-1:0]                  size_code;
    logic [desc_base_w-1:0]                  new_mask;

    assign size_code = cfg.descriptor[desc_size_lsb +: desc_size_w];

    // Size is 4 KiB << code and the low code bits of the page drop out of the compare
    assign new_mask = {desc_base_w{1'b1}} << size_code;

    // Permissions double as valid bits
    always_ff @(posedge clock) begin
        if (!rst_n || cfg.clear) begin
            write_en_q <= '0;
            read_en_q  <= '0;
            next_slot  <= '0;
            count_q    <= '0;
        end else if (cfg.add) begin
            write_en_q[next_slot] <= cfg.descriptor[desc_write_bit];
            read_en_q[next_slot]  <= cfg.descriptor[desc_read_bit];
            next_slot             <= next_slot + 1'b1;  // Wraps to the oldest
            if (count_q != count_w'(num_regions))
                count_q <= count_q + 1'b1;              // Saturates at eight
        end
    end

    // Base and mask only matter while the slot has a permission
    always_ff @(posedge clock) begin
        if (cfg.add) begin
            base_q[next_slot] <= cfg.descriptor[desc_base_lsb +: desc_base_w];
            mask_q[next_slot] <= new_mask;
        end
    end

    assign regions.base     = base_q;
    assign regions.mask     = mask_q;
    assign regions.write_en = write_en_q;
    assign regions.read_en  = read_en_q;
    assign cfg.region_count = count_q;

endmodule

`default_nettype wire

//--- source/mpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mpu_top (
    input  logic        clock,
    input  logic        rst_n,

    // CPU data port with faults one cycle later
    input  logic        mem_request,     // Access this cycle
    input  logic        mem_write,       // 0 load, 1 store
    input  logic [31:0] mem_addr,
    input  logic        supervisor_mode, // Bypasses all checks

    // Register port
    input  logic        cfg_write,
    input  logic        cfg_read,
    input  logic [1:0]  cfg_addr,
    input  logic [31:0] cfg_wdata,
    output logic [31:0] cfg_rdata,

    output logic        load_fault,
    output logic        store_fault
);

    mpu_cfg_if    cfg_bus ();     // Register block to table
    mpu_region_if region_bus ();  // Table to checker
    mpu_fault_if  fault_bus ();   // Checker back to registers

    mpu_cfg_regs u_cfg_regs (
        .clock     (clock),
        .rst_n     (rst_n),
        .cfg_write (cfg_write),
        .cfg_read  (cfg_read),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .cfg       (cfg_bus.regs),
        .fault     (fault_bus.regs)
    );

    mpu_region_table u_region_table (
        .clock   (clock),
        .rst_n   (rst_n),
        .cfg     (cfg_bus.tbl),
        .regions (region_bus.tbl)
    );

    mpu_access_check u_access_check (
        .clock           (clock),
        .rst_n           (rst_n),
        .mem_request     (mem_request),
        .mem_write       (mem_write),
        .mem_addr        (mem_addr),
        .supervisor_mode (supervisor_mode),
        .regions         (region_bus.check),
        .load_fault      (load_fault),
        .store_fault     (store_fault),
        .fault           (fault_bus.check)
    );

endmodule

`default_nettype wire
